// ==== verilog/vrc6_pkg.sv ====
// VRC6 mapper shared types and constants

package vrc6_pkg;

	typedef logic [15:0] cpu_addr_t;  // CPU bus address
	typedef logic [13:0] ppu_addr_t;  // PPU bus address
	typedef logic [7:0]  byte_t;
	typedef logic [21:0] mem_addr_t;  // Cartridge memory address
	typedef logic [15:0] audio_t;
	typedef logic [5:0]  prg_bank_t;  // 8 KB PRG bank number
	typedef logic [7:0]  chr_bank_t;  // 1 KB CHR bank number
	typedef logic [11:0] freq_t;      // Channel period
	typedef logic [3:0]  vol_t;

	// Nametable arrangement, as written to bits 3:2 of $B003
	typedef enum logic [1:0] {
		mirror_vertical   = 2'd0,
		mirror_horizontal = 2'd1,
		mirror_single_a   = 2'd2,
		mirror_single_b   = 2'd3
	} mirror_e;

	// Unit that a forwarded register write goes to
	typedef enum logic [1:0] {
		unit_pulse0 = 2'd0,
		unit_pulse1 = 2'd1,
		unit_saw    = 2'd2,
		unit_irq    = 2'd3
	} reg_unit_e;

	localparam logic [8:0] PRG_RAM_BASE   = 9'b111100000;  // Work RAM window
	localparam prg_bank_t  PRG_FIXED_BANK = '1;            // Last 8 KB bank
	localparam logic [2:0] CHR_REGION     = 3'b100;

	// Prescaler reloads give periods of 114, 114 and 113 ticks
	localparam logic [6:0] PRESCALE_LONG  = 7'd113;
	localparam logic [6:0] PRESCALE_SHORT = 7'd112;

	localparam logic [2:0] SAW_STEPS = 3'd6;  // Last step before the clear

endpackage

// ==== verilog/vrc6_reg_if.sv ====
// Decoded register write bus

interface vrc6_reg_if;

	logic                  wr;      // One cycle write strobe
	vrc6_pkg::reg_unit_e   target;  // Addressed unit
	logic [1:0]            idx;     // Register within the unit
	vrc6_pkg::byte_t       data;

	modport ctrl (
		output wr,
		output target,
		output idx,
		output data
	);

	modport unit (
		input wr,
		input target,
		input idx,
		input data
	);

endinterface

// ==== verilog/vrc6_regs.sv ====
// VRC6 write decode and bank registers

module vrc6_regs (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     ce,
	input  logic                     addr_swap,  // Mapper 26 wiring
	input  vrc6_pkg::cpu_addr_t      prg_ain,
	input  vrc6_pkg::byte_t          prg_din,
	input  logic                     prg_write,
	output logic [4:0]               prg_bank16,
	output vrc6_pkg::prg_bank_t      prg_bank8,
	output vrc6_pkg::chr_bank_t [7:0] chr_banks,
	output vrc6_pkg::mirror_e        mirror,
	vrc6_reg_if.ctrl                 regs
);

	vrc6_pkg::cpu_addr_t ain;
	logic [5:0]          sel;
	logic                unit_hit;
	vrc6_pkg::reg_unit_e unit_sel;

	// Mapper 26 exchanges A0 and A1 on the board
	assign ain = addr_swap ? {prg_ain[15:2], prg_ain[0], prg_ain[1]} : prg_ain;
	assign sel = {ain[15:12], ain[1:0]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prg_bank16 <= '0;
			prg_bank8  <= '0;
			chr_banks  <= '0;
			mirror     <= vrc6_pkg::mirror_vertical;
		end else if (ce && prg_write) begin
			casez (sel)
				6'b1000_??: prg_bank16 <= prg_din[4:0];  // $800x
				6'b1011_11: mirror <= vrc6_pkg::mirror_e'(prg_din[3:2]);  // $B003
				6'b1100_??: prg_bank8 <= prg_din[5:0];  // $C00x
				6'b1101_??,
				6'b1110_??: chr_banks[{ain[13], ain[1:0]}] <= prg_din;  // $D000-$E003
				default: ;
			endcase
		end
	end

	// Sound and IRQ registers sit at index 0 to 2 of their page
	always_comb begin
		unit_hit = 1'b1;
		unit_sel = vrc6_pkg::unit_pulse0;
		case (ain[15:12])
			4'h9: unit_sel = vrc6_pkg::unit_pulse0;
			4'hA: unit_sel = vrc6_pkg::unit_pulse1;
			4'hB: unit_sel = vrc6_pkg::unit_saw;
			4'hF: unit_sel = vrc6_pkg::unit_irq;
			default: unit_hit = 1'b0;
		endcase
	end

	assign regs.wr     = ce && prg_write && unit_hit && (ain[1:0] != 2'b11);
	assign regs.target = unit_sel;
	assign regs.idx    = ain[1:0];
	assign regs.data   = prg_din;

endmodule

// ==== verilog/vrc6_bank_map.sv ====
// PRG and CHR address translation

module vrc6_bank_map (
	input  vrc6_pkg::cpu_addr_t       prg_ain,
	input  logic                      prg_write,
	input  vrc6_pkg::ppu_addr_t       chr_ain,
	input  logic [4:0]                prg_bank16,
	input  vrc6_pkg::prg_bank_t       prg_bank8,
	input  vrc6_pkg::chr_bank_t [7:0] chr_banks,
	input  vrc6_pkg::mirror_e         mirror,
	output vrc6_pkg::mem_addr_t       prg_aout,
	output logic                      prg_allow,
	output vrc6_pkg::mem_addr_t       chr_aout,
	output logic                      vram_a10,
	output logic                      vram_ce
);

	logic prg_is_ram;

	assign prg_is_ram = (prg_ain[15:13] == 3'b011);  // $6000-$7FFF

	always_comb begin
		case (prg_ain[15:13])
			3'b100,
			3'b101:  prg_aout = {3'b000, prg_bank16, prg_ain[13], prg_ain[12:0]};
			3'b110:  prg_aout = {3'b000, prg_bank8, prg_ain[12:0]};
			3'b111:  prg_aout = {3'b000, vrc6_pkg::PRG_FIXED_BANK, prg_ain[12:0]};
			default: prg_aout = {vrc6_pkg::PRG_RAM_BASE, prg_ain[12:0]};
		endcase
	end

	// ROM is read only, work RAM takes both directions
	assign prg_allow = (prg_ain[15] && !prg_write) || prg_is_ram;

	assign chr_aout = {vrc6_pkg::CHR_REGION, 1'b0, chr_banks[chr_ain[12:10]], chr_ain[9:0]};

	assign vram_ce = chr_ain[13];  // Nametable space goes to console VRAM

	always_comb begin
		case (mirror)
			vrc6_pkg::mirror_vertical:   vram_a10 = chr_ain[10];
			vrc6_pkg::mirror_horizontal: vram_a10 = chr_ain[11];
			vrc6_pkg::mirror_single_a:   vram_a10 = 1'b0;
			default:                     vram_a10 = 1'b1;
		endcase
	end

endmodule

// ==== verilog/vrc6_irq.sv ====
// VRC scanline and cycle IRQ counter

module vrc6_irq (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     ce,
	vrc6_reg_if.unit regs,
	output logic     irq
);

	vrc6_pkg::byte_t latch;
	vrc6_pkg::byte_t counter;
	logic [6:0]      prescaler;
	logic [1:0]      line;      // Position in the 114/114/113 pattern
	logic            mode_m;    // Count every CPU cycle
	logic            enable_e;
	logic            enable_a;  // E value restored by acknowledge
	logic            sel;
	logic            count_tick;

	assign sel        = regs.wr && (regs.target == vrc6_pkg::unit_irq);
	assign count_tick = mode_m || (prescaler == 7'd0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			latch     <= '0;
			counter   <= '0;
			prescaler <= '0;
			line      <= '0;
			mode_m    <= 1'b0;
			enable_e  <= 1'b0;
			enable_a  <= 1'b0;
			irq       <= 1'b0;
		end else if (sel) begin
			case (regs.idx)
				2'd0: latch <= regs.data;
				2'd1: begin
					{mode_m, enable_e, enable_a} <= regs.data[2:0];
					irq <= 1'b0;
					if (regs.data[1]) begin
						counter   <= latch;  // Restart from the latch
						prescaler <= vrc6_pkg::PRESCALE_LONG;
						line      <= 2'd0;
					end
				end
				default: begin  // Acknowledge
					irq      <= 1'b0;
					enable_e <= enable_a;
				end
			endcase
		end else if (ce && enable_e) begin
			if (prescaler != 7'd0) begin
				prescaler <= prescaler - 7'd1;
			end else begin
				prescaler <= (line == 2'd1) ? vrc6_pkg::PRESCALE_SHORT
					: vrc6_pkg::PRESCALE_LONG;
				line      <= line[1] ? 2'd0 : line + 2'd1;
			end
			if (count_tick) begin
				if (counter == 8'hFF) begin
					counter <= latch;
					irq     <= 1'b1;
				end else begin
					counter <= counter + 8'd1;
				end
			end
		end
	end

endmodule

// ==== verilog/vrc6_pulse.sv ====
// VRC6 pulse channel

module vrc6_pulse #(
	parameter vrc6_pkg::reg_unit_e UNIT = vrc6_pkg::unit_pulse0
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           ce,
	vrc6_reg_if.unit       regs,
	output vrc6_pkg::vol_t level
);

	logic            mode;  // Ignore duty, output a flat level
	logic [2:0]      duty;
	vrc6_pkg::vol_t  vol;
	vrc6_pkg::freq_t freq;
	logic            en;
	vrc6_pkg::freq_t div;
	logic [3:0]      step;   // Duty position
	logic            sel;

	assign sel = regs.wr && (regs.target == UNIT);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			{mode, duty, vol} <= '0;
			freq <= '0;
			en   <= 1'b0;
			div  <= '0;
			step <= '0;
		end else begin
			if (sel) begin
				case (regs.idx)
					2'd0:    {mode, duty, vol} <= regs.data;
					2'd1:    freq[7:0] <= regs.data;
					default: {en, freq[11:8]} <= {regs.data[7], regs.data[3:0]};
				endcase
			end
			if (ce && en) begin
				if (div != '0) begin
					div <= div - 12'd1;
				end else begin
					div  <= freq;
					step <= step + 4'd1;
				end
			end
		end
	end

	assign level = (en && (mode || (step <= {1'b0, duty}))) ? vol : '0;

endmodule

// ==== verilog/vrc6_saw.sv ====
// VRC6 sawtooth channel

module vrc6_saw (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       ce,
	vrc6_reg_if.unit   regs,
	output logic [4:0] level
);

	logic [5:0]      rate;  // Accumulator increment
	vrc6_pkg::freq_t freq;
	logic            en;
	logic [12:0]     div;
	logic [2:0]      step;
	logic [7:0]      acc;
	logic            sel;

	assign sel = regs.wr && (regs.target == vrc6_pkg::unit_saw);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rate <= '0;
			freq <= '0;
			en   <= 1'b0;
			div  <= '0;
			step <= '0;
			acc  <= '0;
		end else begin
			if (sel) begin
				case (regs.idx)
					2'd0:    rate <= regs.data[5:0];
					2'd1:    freq[7:0] <= regs.data;
					default: {en, freq[11:8]} <= {regs.data[7], regs.data[3:0]};
				endcase
			end
			if (ce && en) begin
				if (div != '0) begin
					div <= div - 13'd1;
				end else begin
					div <= {freq, 1'b1};  // Twice the period plus one
					if (step == vrc6_pkg::SAW_STEPS) begin
						step <= '0;
						acc  <= '0;
					end else begin
						step <= step + 3'd1;
						acc  <= acc + {2'b00, rate};
					end
				end
			end
		end
	end

	assign level = en ? acc[7:3] : '0;

endmodule

// ==== verilog/vrc6_mixer.sv ====
// Expansion sound mixer

module vrc6_mixer (
	input  logic             clk,
	input  logic             arst_n,
	input  vrc6_pkg::vol_t   sq0,
	input  vrc6_pkg::vol_t   sq1,
	input  logic [4:0]       saw,
	input  vrc6_pkg::audio_t audio_in,
	output vrc6_pkg::audio_t audio_out
);

	logic [5:0]       sum;
	vrc6_pkg::audio_t wide;   // Sum stretched to full scale
	logic [16:0]      total;

	assign sum  = {2'b00, sq0} + {2'b00, sq1} + {1'b0, saw};
	assign wide = {sum, sum, sum[5:2]};

	// Expansion at 5/8 scale, then the whole mix halved
	assign total = {1'b0, audio_in} + {2'b00, wide[15:1]} + {4'b0000, wide[15:3]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			audio_out <= '0;
		end else begin
			audio_out <= total[16:1];
		end
	end

endmodule

// ==== verilog/vrc6_top.sv ====
// Konami VRC6 mapper top level

module vrc6_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                ce,         // CPU cycle tick
	input  logic                addr_swap,  // High for mapper 26
	input  vrc6_pkg::cpu_addr_t prg_ain,
	input  vrc6_pkg::byte_t     prg_din,
	input  logic                prg_write,
	input  vrc6_pkg::ppu_addr_t chr_ain,
	input  vrc6_pkg::audio_t    audio_in,   // APU audio
	output vrc6_pkg::mem_addr_t prg_aout,
	output logic                prg_allow,
	output vrc6_pkg::mem_addr_t chr_aout,
	output logic                vram_a10,
	output logic                vram_ce,
	output logic                irq,
	output vrc6_pkg::audio_t    audio_out
);

	logic [4:0]                prg_bank16;
	vrc6_pkg::prg_bank_t       prg_bank8;
	vrc6_pkg::chr_bank_t [7:0] chr_banks;
	vrc6_pkg::mirror_e         mirror;
	vrc6_pkg::vol_t            sq0_level;
	vrc6_pkg::vol_t            sq1_level;
	logic [4:0]                saw_level;

	vrc6_reg_if regs ();

	vrc6_regs u_regs (
		.clk, .arst_n, .ce, .addr_swap, .prg_ain, .prg_din, .prg_write,
		.prg_bank16, .prg_bank8, .chr_banks, .mirror,
		.regs (regs.ctrl)
	);

	vrc6_bank_map u_bank_map (
		.prg_ain, .prg_write, .chr_ain, .prg_bank16, .prg_bank8, .chr_banks, .mirror,
		.prg_aout, .prg_allow, .chr_aout, .vram_a10, .vram_ce
	);

	vrc6_irq u_irq (.clk, .arst_n, .ce, .regs (regs.unit), .irq);

	vrc6_pulse #(.UNIT (vrc6_pkg::unit_pulse0)) u_pulse0 (
		.clk, .arst_n, .ce, .regs (regs.unit), .level (sq0_level)
	);

	vrc6_pulse #(.UNIT (vrc6_pkg::unit_pulse1)) u_pulse1 (
		.clk, .arst_n, .ce, .regs (regs.unit), .level (sq1_level)
	);

	vrc6_saw u_saw (.clk, .arst_n, .ce, .regs (regs.unit), .level (saw_level));

	vrc6_mixer u_mixer (
		.clk, .arst_n,
		.sq0 (sq0_level), .sq1 (sq1_level), .saw (saw_level),
		.audio_in, .audio_out
	);

endmodule

// ==== bench/vrc6_properties.sv ====
// VRC6 reference checks

module vrc6_properties (
	input logic                clk,
	input logic                arst_n,
	input logic                ce,
	input logic                addr_swap,
	input vrc6_pkg::cpu_addr_t prg_ain,
	input vrc6_pkg::byte_t     prg_din,
	input logic                prg_write,
	input vrc6_pkg::ppu_addr_t chr_ain,
	input vrc6_pkg::audio_t    audio_in,
	input vrc6_pkg::mem_addr_t prg_aout,
	input logic                prg_allow,
	input vrc6_pkg::mem_addr_t chr_aout,
	input logic                vram_a10,
	input logic                vram_ce,
	input logic                irq,
	input vrc6_pkg::audio_t    audio_out
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;  // Read by the testbench

	logic [5:0]      page;  // A15-A12 and swapped A1-A0
	logic            wr;
	logic [4:0]      b16;
	logic [5:0]      b8;
	vrc6_pkg::chr_bank_t chr [8];
	logic [1:0]      mir;
	logic            sq0_mode, sq0_en, sq1_en, saw_en;
	vrc6_pkg::vol_t  sq0_vol;
	vrc6_pkg::byte_t prg_latch;  // IRQ latch shadow
	logic            armed;
	int              ticks_left;  // Ticks until the IRQ in cycle mode
	vrc6_pkg::mem_addr_t exp_prg;
	vrc6_pkg::mem_addr_t exp_chr;
	logic            exp_allow;
	logic            exp_a10;
	logic [5:0]      lvl;
	logic [15:0]     wide;
	logic [16:0]     total;
	logic [15:0]     exp_audio;
	logic            audio_known;

	assign page = {prg_ain[15:12], addr_swap ? {prg_ain[0], prg_ain[1]} : prg_ain[1:0]};
	assign wr   = ce && prg_write;

	always_comb begin
		case (prg_ain[15:13])
			3'b100, 3'b101: exp_prg = {3'b000, b16, prg_ain[13:0]};
			3'b110:         exp_prg = {3'b000, b8, prg_ain[12:0]};
			3'b111:         exp_prg = {3'b000, 6'h3F, prg_ain[12:0]};
			default:        exp_prg = {9'b111100000, prg_ain[12:0]};
		endcase
		// Work RAM in both directions, ROM only for reads
		exp_allow = (prg_ain inside {[16'h6000:16'h7FFF]})
			|| (prg_ain >= 16'h8000 && !prg_write);
		exp_chr = {4'b1000, chr[chr_ain[12:10]], chr_ain[9:0]};
		case (mir)
			2'd0:    exp_a10 = chr_ain[10];
			2'd1:    exp_a10 = chr_ain[11];
			2'd2:    exp_a10 = 1'b0;
			default: exp_a10 = 1'b1;
		endcase
		lvl   = sq0_en ? {2'b00, sq0_vol} : 6'd0;
		wide  = {lvl, lvl, lvl[5:2]};
		total = {1'b0, audio_in} + (wide >> 1) + (wide >> 3);
		audio_known = !sq1_en && !saw_en && (!sq0_en || sq0_mode);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			b16 <= '0;
			b8 <= '0;
			for (int i = 0; i < 8; i++) chr[i] <= '0;
			mir <= '0;
			{sq0_mode, sq0_en, sq1_en, saw_en} <= '0;
			sq0_vol <= '0;
			armed <= 1'b0;
			ticks_left <= 0;
		end else if (wr) begin
			case (page[5:2])
				4'h8: b16 <= prg_din[4:0];
				4'hC: b8 <= prg_din[5:0];
				4'hD: chr[{1'b0, page[1:0]}] <= prg_din;
				4'hE: chr[{1'b1, page[1:0]}] <= prg_din;
				default: ;
			endcase
			if (page == 6'b1001_00) {sq0_mode, sq0_vol} <= {prg_din[7], prg_din[3:0]};
			if (page == 6'b1001_10) sq0_en <= prg_din[7];
			if (page == 6'b1010_10) sq1_en <= prg_din[7];
			if (page == 6'b1011_10) saw_en <= prg_din[7];
			if (page == 6'b1011_11) mir <= prg_din[3:2];
			if (page == 6'b1111_01) begin
				armed <= (prg_din[2:1] == 2'b11);
				ticks_left <= 256 - int'(prg_latch);
			end
			if (page == 6'b1111_10) armed <= 1'b0;
		end else if (ce && armed) begin
			ticks_left <= ticks_left - 1;
			if (ticks_left == 1) armed <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prg_latch <= '0;
			exp_audio <= '0;
		end else begin
			exp_audio <= total[16:1];  // Mixer output one clock on
			if (wr && page == 6'b1111_00) prg_latch <= prg_din;
		end
	end

	a_reset: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |-> (!irq && audio_out == 0))
		else begin
			fail_count++;
			$error("** Error t=%0t irq=%b audio_out=%h expected 0", $time, irq, audio_out);
		end

	a_prg_aout: assert property (@(posedge clk) disable iff (!arst_n)
		prg_ain[15:13] >= 3'b011 |-> prg_aout == exp_prg)
		else begin
			fail_count++;
			$error("** Error t=%0t prg_aout exp %h got %h", $time, exp_prg, prg_aout);
		end

	a_prg_allow: assert property (@(posedge clk) disable iff (!arst_n)
		prg_allow == exp_allow)
		else begin
			fail_count++;
			$error("** Error t=%0t prg_allow exp %b got %b", $time, exp_allow, prg_allow);
		end

	a_chr: assert property (@(posedge clk) disable iff (!arst_n)
		chr_aout == exp_chr)
		else begin
			fail_count++;
			$error("** Error t=%0t chr_aout exp %h got %h", $time, exp_chr, chr_aout);
		end

	a_vram_a10: assert property (@(posedge clk) disable iff (!arst_n)
		vram_a10 == exp_a10)
		else begin
			fail_count++;
			$error("** Error t=%0t vram_a10 exp %b got %b", $time, exp_a10, vram_a10);
		end

	a_vram_ce: assert property (@(posedge clk) disable iff (!arst_n)
		vram_ce == chr_ain[13])
		else begin
			fail_count++;
			$error("** Error t=%0t vram_ce exp %b got %b", $time, chr_ain[13], vram_ce);
		end

	a_irq_early: assert property (@(posedge clk) disable iff (!arst_n)
		armed && ticks_left > 1 |=> !irq)
		else begin
			fail_count++;
			$error("IRQ rose before the counter passed 255");
		end

	a_irq_rise: assert property (@(posedge clk) disable iff (!arst_n)
		armed && ce && !wr && ticks_left == 1 |=> irq)
		else begin
			fail_count++;
			$error("IRQ did not rise when the counter passed 255");
		end

	a_irq_ack: assert property (@(posedge clk) disable iff (!arst_n)
		wr && page == 6'b1111_10 |=> !irq)
		else begin
			fail_count++;
			$error("IRQ stayed high after acknowledge");
		end

	a_audio: assert property (@(posedge clk) disable iff (!arst_n)
		audio_known |=> audio_out == exp_audio)
		else begin
			fail_count++;
			$error("** Error t=%0t audio_out exp %h got %h", $time, exp_audio, audio_out);
		end

endmodule

bind vrc6_top vrc6_properties u_props (.*);

// ==== bench/vrc6_tb.sv ====
// VRC6 mapper testbench

module vrc6_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WATCHDOG_CYCLES = 10 + 2 * 120 + 200 + 1200 + 100 + 500;

	logic clk = 0, arst_n = 0, ce = 0, addr_swap = 0, prg_write = 0;
	vrc6_pkg::cpu_addr_t prg_ain = '0;
	vrc6_pkg::byte_t     prg_din = '0;
	vrc6_pkg::ppu_addr_t chr_ain = '0;
	vrc6_pkg::audio_t    audio_in = '0;
	vrc6_pkg::mem_addr_t prg_aout, chr_aout;
	logic prg_allow, vram_a10, vram_ce, irq;
	vrc6_pkg::audio_t audio_out;
	logic [1:0] ce_phase = 0;
	int seed = 32'hc78b_ba00;
	int tests = 0, failed_tests = 0, bench_errors = 0, start_errors;

	vrc6_top dut0 (.*);

	initial forever #10 clk = ~clk;

	always @(posedge clk) begin  // ce every fourth clock
		#2;
		ce = (ce_phase == 2'd3);
		ce_phase = ce_phase + 2'd1;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk);
		while (ce_phase != 2'd3) @(posedge clk);
		#2;
		prg_ain = a;
		prg_din = d;
		prg_write = 1'b1;
		@(posedge clk);
		#2;
		prg_write = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic begin_test();
		start_errors = dut0.u_props.fail_count + bench_errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (dut0.u_props.fail_count + bench_errors != start_errors) begin
			failed_tests++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	initial begin
		int n;
		logic [31:0] r;
		logic w;
		begin_test();
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#2 chr_ain = $random(seed);
		end
		arst_n = 1'b1;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#2 chr_ain = $random(seed);
		end
		end_test("reset");

		begin_test();
		for (int s = 0; s < 2; s++) begin
			addr_swap = s[0];
			cpu_write(16'h8000, $random(seed));
			cpu_write(16'hC000, $random(seed));
			for (int i = 0; i < 40; i++) begin
				@(posedge clk);
				r = $random(seed);
				w = r[20] && (ce_phase != 2'd3);  // Keep writes off the ce tick
				#2;
				prg_ain = {3'd3 + r[18:16] % 3'd5, r[12:0]};  // $6000-$FFFF
				prg_write = w;
			end
			prg_write = 1'b0;
		end
		addr_swap = 1'b0;
		end_test("prg mapping");

		begin_test();
		addr_swap = 1'b1;
		for (int i = 0; i < 8; i++) begin
			// Board swaps A0 and A1 back to bank i
			cpu_write(16'hD000 + ((i & 4) << 10) + {i[0], i[1]}, $random(seed));
		end
		addr_swap = 1'b0;
		for (int m = 0; m < 4; m++) begin
			cpu_write(16'hB003, m << 2);
			for (int i = 0; i < 16; i++) begin
				@(posedge clk);
				#2 chr_ain = $random(seed);
			end
		end
		end_test("chr mapping");

		begin_test();
		cpu_write(16'hF000, 8'hE0 | ($random(seed) & 8'h1F));
		cpu_write(16'hF001, 8'h06);
		n = 0;
		while (!irq && n < 1100) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!irq) begin
			bench_errors++;
			$display("IRQ never rose in cycle mode");
		end
		cpu_write(16'hF002, 8'h00);
		idle(2);
		end_test("irq");

		begin_test();
		audio_in = $random(seed);
		cpu_write(16'h9000, 8'h80 | ($random(seed) & 8'h0F));
		cpu_write(16'h9002, 8'h80);
		idle(20);
		cpu_write(16'h9002, 8'h00);
		idle(20);
		end_test("audio");

		$display("tests %0d, failed %0d, assertion errors %0d", tests, failed_tests,
			dut0.u_props.fail_count);
		if (failed_tests == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
verilog/vrc6_pkg.sv
verilog/vrc6_reg_if.sv
verilog/vrc6_regs.sv
verilog/vrc6_bank_map.sv
verilog/vrc6_irq.sv
verilog/vrc6_pulse.sv
verilog/vrc6_saw.sv
verilog/vrc6_mixer.sv
verilog/vrc6_top.sv
bench/vrc6_properties.sv
bench/vrc6_tb.sv

// ==== Bender.yml ====
package:
  name: vrc6

sources:
  - files:
      - verilog/vrc6_pkg.sv
      - verilog/vrc6_reg_if.sv
      - verilog/vrc6_regs.sv
      - verilog/vrc6_bank_map.sv
      - verilog/vrc6_irq.sv
      - verilog/vrc6_pulse.sv
      - verilog/vrc6_saw.sv
      - verilog/vrc6_mixer.sv
      - verilog/vrc6_top.sv
  - target: test
    files:
      - bench/vrc6_properties.sv
      - bench/vrc6_tb.sv
